// File: tb.f
logic/uart_frame_pkg.sv
logic/uart_bit_tx.sv
logic/uart_bit_rx.sv
logic/frame_sender.sv
logic/frame_receiver.sv
logic/uart_frame_top.sv
test/uart_frame_assertions.sv
test/tb_uart_frame.sv

// File: test/tb_uart_frame.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framed uart link testbench.
// loopback and raw serial injection tests
// with a watchdog on the whole run.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_uart_frame;

	localparam int     frame_count = 10;                  // frames and injections, rounded up.
	localparam longint watchdog_ns = longint'(frame_count) * 20 * 10
	                                 * uart_frame_pkg::clks_per_bit * 40 + 20000;

	logic                       sys_clk = 1'b0;
	logic                       sys_rst_n;
	uart_frame_pkg::frame_buf_t tx_string;
	uart_frame_pkg::frame_len_t tx_length;
	logic                       tx_req;
	logic                       tx_ack;
	logic                       tx_busy;
	uart_frame_pkg::frame_buf_t rx_string;
	uart_frame_pkg::frame_len_t rx_length;
	logic                       rx_req;
	logic                       rx_ack;
	logic                       uart_tx_port;
	logic                       serial_line;
	logic                       inject_en;
	logic                       inject_line;
	logic [31:0]                rng_state;

	always #20 sys_clk = ~sys_clk;

	// loopback unless a test injects raw bytes.
	assign serial_line = inject_en ? inject_line : uart_tx_port;

	uart_frame_top dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.tx_busy      (tx_busy),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.uart_rx_port (serial_line),
		.uart_tx_port (uart_tx_port)
	);

	// ~~~~~~~~ helpers ~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic uart_frame_pkg::byte_t random_byte();
		uart_frame_pkg::byte_t b;
		rng_state = xorshift32(rng_state);
		b = rng_state[7:0];
		if (b == uart_frame_pkg::frame_char) begin
			b = b ^ 8'h01;                                // keep "&" out of payloads.
		end
		return b;
	endfunction

	function automatic uart_frame_pkg::frame_buf_t text_to_buf(input string text);
		uart_frame_pkg::frame_buf_t b;
		b = '0;
		for (int i = 0; i < text.len(); i++) begin
			b[8 * i +: 8] = text[i];
		end
		return b;
	endfunction

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// ~~~~~~~~ host side handshakes ~~~~~~~~~~
	task automatic send_string(input uart_frame_pkg::frame_buf_t s, input int len);
		@(posedge sys_clk);
		tx_string <= s;
		tx_length <= uart_frame_pkg::frame_len_t'(len);
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		while (!tx_ack) @(posedge sys_clk);
		check_value(tx_busy, 1'b1, "tx_busy at tx_ack");
		tx_req <= 1'b0;
		@(posedge sys_clk);
		while (tx_ack) @(posedge sys_clk);
		check_value(tx_busy, 1'b0, "tx_busy after send");
	endtask

	task automatic receive_frame(input uart_frame_pkg::frame_buf_t exp_string, input int len);
		while (!rx_req) @(posedge sys_clk);
		check_value(rx_length, len, "rx_length");
		for (int i = 0; i < len; i++) begin
			check_value(rx_string[8 * i +: 8], exp_string[8 * i +: 8], "rx_string byte");
		end
		rx_ack <= 1'b1;
		@(posedge sys_clk);
		while (rx_req) @(posedge sys_clk);
		rx_ack <= 1'b0;
		@(posedge sys_clk);
	endtask

	// ~~~~~~~~ raw serial injection ~~~~~~~~~~
	task automatic inject_byte(input uart_frame_pkg::byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};                           // stop, data, start.
		for (int i = 0; i < 10; i++) begin
			inject_line <= bits[i];
			repeat (uart_frame_pkg::clks_per_bit) @(posedge sys_clk);
		end
	endtask

	task automatic inject_text(input string text);
		for (int i = 0; i < text.len(); i++) begin
			inject_byte(text[i]);
		end
	endtask

	task automatic expect_no_frame(input string what);
		repeat (10 * uart_frame_pkg::clks_per_bit) @(posedge sys_clk);
		check_value(rx_req, 1'b0, what);
	endtask

	// ~~~~~~~~ directed tests ~~~~~~~~~~~~~~~~
	task automatic reset_test();
		check_value(uart_tx_port, 1'b1, "uart_tx_port after reset");
		check_value(tx_ack, 1'b0, "tx_ack after reset");
		check_value(tx_busy, 1'b0, "tx_busy after reset");
		check_value(rx_req, 1'b0, "rx_req after reset");
	endtask

	task automatic loopback_test(input int len);
		uart_frame_pkg::frame_buf_t payload;
		payload = '0;
		for (int i = 0; i < len; i++) begin
			payload[8 * i +: 8] = random_byte();
		end
		fork
			send_string(payload, len);
			receive_frame(payload, len);
		join
	endtask

	task automatic garbage_test();
		@(posedge sys_clk);
		inject_en <= 1'b1;
		repeat (4) inject_byte(random_byte());
		inject_text("&Q");                                // lone delimiter, back to hunt.
		check_value(rx_req, 1'b0, "rx_req after garbage");
		inject_text("&&AB&&");
		receive_frame(text_to_buf("AB"), 2);
		expect_no_frame("rx_req after single frame");
	endtask

	task automatic overlong_test();
		inject_text("&&ABCDEFGHIJKLMNOPQ&&");
		expect_no_frame("rx_req after 17 byte frame");
		inject_text("&Z");                                // trailing pair reopened a frame.
		expect_no_frame("rx_req after reopened frame");
		inject_text("&&CD&&");
		receive_frame(text_to_buf("CD"), 2);
	endtask

	task automatic bad_close_test();
		inject_text("&&AB&Z");
		expect_no_frame("rx_req after bad closing");
	endtask

	// ~~~~~~~~ main sequence ~~~~~~~~~~~~~~~~~
	initial begin
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		rx_ack      = 1'b0;
		inject_en   = 1'b0;
		inject_line = 1'b1;                               // idle line level.
		rng_state   = 32'h8bf717b5;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		reset_test();
		loopback_test(1);
		loopback_test(5);
		loopback_test(16);
		loopback_test(0);                                 // "&&&&" frame.
		garbage_test();
		overlong_test();
		bad_close_test();
		if (dut.u_assertions.error_count != 0) begin
			$display("[ERROR] %0t ns: %0d assertion failures", $time,
			         dut.u_assertions.error_count);
			$display("Something failed");
			$fatal(1);
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Something failed");
		$fatal(1);
	end

endmodule

// File: test/uart_frame_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framed uart link protocol checker.
// handshake order and reset values of the
// sender, receiver and byte engine.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_frame_assertions (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_req,
	input logic tx_ack,
	input logic tx_busy,
	input logic rx_req,
	input logic rx_ack,
	input logic byte_req,
	input logic byte_ack
);

	int error_count = 0;                              // failures seen so far.

	rx_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_req && !rx_ack |=> rx_req)
		else begin
			error_count++;
			$error("rx_req dropped before rx_ack");
		end

	tx_ack_after_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_ack) |-> tx_req)
		else begin
			error_count++;
			$error("tx_ack raised without tx_req");
		end

	// four-phase order on the byte link.
	byte_req_rise: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(byte_req) |-> !byte_ack)
		else begin
			error_count++;
			$error("byte_req raised while byte_ack still high");
		end

	byte_req_drop: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req && byte_ack |=> !byte_req)
		else begin
			error_count++;
			$error("byte_req held after byte_ack");
		end

	byte_ack_drop: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!byte_req && byte_ack |=> !byte_ack)
		else begin
			error_count++;
			$error("byte_ack held after byte_req fell");
		end

	reset_values: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |-> !tx_ack && !tx_busy && !rx_req && !byte_req && !byte_ack)
		else begin
			error_count++;
			$error("control outputs not low after reset");
		end

endmodule

bind uart_frame_top uart_frame_assertions u_assertions (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_req    (tx_req),
	.tx_ack    (tx_ack),
	.tx_busy   (tx_busy),
	.rx_req    (rx_req),
	.rx_ack    (rx_ack),
	.byte_req  (byte_req),
	.byte_ack  (byte_ack)
);

// File: logic/uart_frame_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framed-string uart link top level.
// joins the frame sender and receiver to
// the two serial bit engines.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_frame_top (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,

	input  uart_frame_pkg::frame_buf_t tx_string,
	input  uart_frame_pkg::frame_len_t tx_length,
	input  logic                       tx_req,
	output logic                       tx_ack,
	output logic                       tx_busy,

	output uart_frame_pkg::frame_buf_t rx_string,
	output uart_frame_pkg::frame_len_t rx_length,
	output logic                       rx_req,
	input  logic                       rx_ack,

	input  logic                       uart_rx_port,
	output logic                       uart_tx_port
);

	uart_frame_pkg::byte_t byte_data;                 // sender to bit tx.
	logic                  byte_req;
	logic                  byte_ack;
	uart_frame_pkg::byte_t rx_byte;                   // bit rx to receiver.
	logic                  rx_byte_valid;

	// ~~~~~~~~ transmit path ~~~~~~~~~~~~~~~~~
	frame_sender u_frame_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_busy   (tx_busy),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_ack  (byte_ack)
	);

	uart_bit_tx u_uart_bit_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_ack  (byte_ack),
		.line      (uart_tx_port)
	);

	// ~~~~~~~~ receive path ~~~~~~~~~~~~~~~~~~
	uart_bit_rx u_uart_bit_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.line          (uart_rx_port),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	frame_receiver u_frame_receiver (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_req        (rx_req),
		.rx_ack        (rx_ack)
	);

endmodule

// File: logic/frame_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame receiver.
// hunts for "&&payload&&" in the received
// bytes and offers the string to the host.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_receiver (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::byte_t      rx_byte,
	input  logic                       rx_byte_valid,
	output uart_frame_pkg::frame_buf_t rx_string,
	output uart_frame_pkg::frame_len_t rx_length,
	output logic                       rx_req,
	input  logic                       rx_ack
);

	typedef enum logic [2:0] {
		recv_hunt,
		recv_open1,
		recv_payload,
		recv_close1,
		recv_offer,
		recv_release
	} recv_state_t;

	recv_state_t state;
	logic        is_delim;
	logic        buf_full;
	logic        store;

	assign is_delim = (rx_byte == uart_frame_pkg::frame_char);
	assign buf_full = (rx_length == uart_frame_pkg::frame_len_t'(uart_frame_pkg::max_len));
	assign store    = (state == recv_payload) && rx_byte_valid && !is_delim && !buf_full;

	// ~~~~~~~~ frame recognition ~~~~~~~~~~~~~
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= recv_hunt;
			rx_length <= '0;
			rx_req    <= 1'b0;
		end else begin
			case (state)
				recv_hunt: begin
					if (rx_byte_valid && is_delim) state <= recv_open1;
				end
				recv_open1: begin
					if (rx_byte_valid) begin
						rx_length <= '0;
						state     <= is_delim ? recv_payload : recv_hunt;
					end
				end
				recv_payload: begin
					if (rx_byte_valid) begin
						if (is_delim) begin
							state <= recv_close1;
						end else if (buf_full) begin
							state <= recv_hunt;           // seventeenth byte, too long.
						end else begin
							rx_length <= rx_length + 1'b1;
						end
					end
				end
				recv_close1: begin
					if (rx_byte_valid) begin
						rx_req <= is_delim;
						state  <= is_delim ? recv_offer : recv_hunt;
					end
				end
				recv_offer: begin
					// incoming bytes are dropped until released.
					if (rx_ack) begin
						rx_req <= 1'b0;
						state  <= recv_release;
					end
				end
				recv_release: begin
					if (!rx_ack) state <= recv_hunt;
				end
				default: state <= recv_hunt;
			endcase
		end
	end

	// ~~~~~~~~ string buffer ~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (store) begin
			rx_string[8 * rx_length +: 8] <= rx_byte;  // byte i at bits 8i+7:8i.
		end
	end

endmodule

// File: logic/frame_sender.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame sender.
// wraps the host string as "&&payload&&"
// and feeds it byte by byte to uart_bit_tx.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_sender (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_buf_t tx_string,
	input  uart_frame_pkg::frame_len_t tx_length,
	input  logic                       tx_req,
	output logic                       tx_ack,
	output logic                       tx_busy,
	output uart_frame_pkg::byte_t      byte_data,
	output logic                       byte_req,
	input  logic                       byte_ack
);

	typedef enum logic [2:0] {
		send_idle,
		send_open1,
		send_open2,
		send_payload,
		send_close1,
		send_close2,
		send_done
	} send_state_t;

	send_state_t                state;
	uart_frame_pkg::frame_len_t byte_cnt;             // next payload byte.
	logic                       sending;
	logic                       byte_done;

	assign sending   = (state != send_idle) && (state != send_done);
	assign byte_done = byte_req && byte_ack;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= send_idle;
			byte_cnt <= '0;
			byte_req <= 1'b0;
			tx_ack   <= 1'b0;
			tx_busy  <= 1'b0;
		end else begin
			// ~~~~~~~~ byte handshake ~~~~~~~~~~~~~~~~
			if (byte_done) begin
				byte_req <= 1'b0;
			end else if (sending && !byte_req && !byte_ack) begin
				byte_req <= 1'b1;                     // previous ack has cleared.
			end

			// ~~~~~~~~ frame sequence ~~~~~~~~~~~~~~~~
			case (state)
				send_idle: begin
					if (tx_req) begin
						tx_busy <= 1'b1;
						state   <= send_open1;
					end
				end
				send_open1:  if (byte_done) state <= send_open2;
				send_open2: begin
					if (byte_done) begin
						byte_cnt <= '0;
						state    <= (tx_length == '0) ? send_close1 : send_payload;
					end
				end
				send_payload: begin
					if (byte_done) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt + 1'b1 == tx_length) state <= send_close1;
					end
				end
				send_close1: if (byte_done) state <= send_close2;
				send_close2: begin
					if (byte_done) begin
						tx_ack <= 1'b1;                   // closing stop bit has ended.
						state  <= send_done;
					end
				end
				send_done: begin
					if (!tx_req) begin
						tx_ack  <= 1'b0;
						tx_busy <= 1'b0;
						state   <= send_idle;
					end
				end
				default: state <= send_idle;
			endcase
		end
	end

	// byte held stable while byte_req is high.
	always_ff @(posedge sys_clk) begin
		if (sending && !byte_req && !byte_ack) begin
			byte_data <= (state == send_payload) ? tx_string[8 * byte_cnt +: 8]
			                                     : uart_frame_pkg::frame_char;
		end
	end

endmodule

// File: logic/uart_bit_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart byte receiver.
// synchronizes the line, finds start bits
// and samples each bit at its middle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_bit_rx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  line,
	output uart_frame_pkg::byte_t rx_byte,
	output logic                  rx_byte_valid
);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t                state;
	logic                     line_meta;
	logic                     line_sync;
	logic                     line_prev;
	uart_frame_pkg::byte_t    rx_shift;
	uart_frame_pkg::clk_cnt_t clk_cnt;
	logic [2:0]               bit_cnt;

	// ~~~~~~~~ line synchronizer ~~~~~~~~~~~~~
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
			line_prev <= 1'b1;
		end else begin
			line_meta <= line;
			line_sync <= line_meta;
			line_prev <= line_sync;                   // for edge detect.
		end
	end

	// ~~~~~~~~ bit sampling ~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= rx_idle;
			clk_cnt       <= '0;
			bit_cnt       <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte_valid <= 1'b0;
			clk_cnt       <= clk_cnt + 1'b1;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					if (line_prev && !line_sync) state <= rx_start;  // falling edge.
				end
				rx_start: begin
					if (clk_cnt == uart_frame_pkg::bit_half) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= line_sync ? rx_idle : rx_data;  // glitch filter.
					end
				end
				rx_data: begin
					if (clk_cnt == uart_frame_pkg::bit_last) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) state <= rx_stop;
					end
				end
				rx_stop: begin
					if (clk_cnt == uart_frame_pkg::bit_last) begin
						rx_byte_valid <= line_sync;           // framing error drops it.
						state         <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data path, lsb arrives first.
	always_ff @(posedge sys_clk) begin
		if (state == rx_data && clk_cnt == uart_frame_pkg::bit_last) begin
			rx_shift <= {line_sync, rx_shift[7:1]};
		end
		if (state == rx_stop && clk_cnt == uart_frame_pkg::bit_last) begin
			rx_byte <= rx_shift;
		end
	end

endmodule

// File: logic/uart_bit_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart byte transmitter.
// sends one 8n1 character per four-phase
// req/ack transfer, lsb first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_bit_tx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_frame_pkg::byte_t byte_data,
	input  logic                  byte_req,
	output logic                  byte_ack,
	output logic                  line
);

	typedef enum logic [1:0] {
		tx_idle,
		tx_shift,
		tx_hold
	} tx_state_t;

	tx_state_t                state;
	logic [9:0]               shift_reg;             // stop, data, start.
	uart_frame_pkg::clk_cnt_t clk_cnt;
	logic [3:0]               bit_cnt;

	assign line = shift_reg[0];                       // all ones when idle.

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= tx_idle;
			shift_reg <= '1;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			byte_ack  <= 1'b0;
		end else begin
			case (state)
				tx_idle: begin
					if (byte_req) begin
						shift_reg <= {1'b1, byte_data, 1'b0};
						clk_cnt   <= '0;
						bit_cnt   <= '0;
						state     <= tx_shift;
					end
				end
				tx_shift: begin
					if (clk_cnt == uart_frame_pkg::bit_last) begin
						clk_cnt   <= '0;
						shift_reg <= {1'b1, shift_reg[9:1]};   // fill with idle level.
						bit_cnt   <= bit_cnt + 4'd1;
						if (bit_cnt == 4'd9) begin            // stop bit done.
							byte_ack <= 1'b1;
							state    <= tx_hold;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				tx_hold: begin
					if (!byte_req) begin                      // four-phase return.
						byte_ack <= 1'b0;
						state    <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

// File: logic/uart_frame_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framed-string uart link shared definitions.
// bit timing, frame character and the
// width types used across the link.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_frame_pkg;

	// ~~~~~~~~ serial timing ~~~~~~~~~~~~~~~~~
	localparam int clks_per_bit = 8;                  // short bit time for simulation.
	localparam int clk_cnt_w    = $clog2(clks_per_bit);

	typedef logic [clk_cnt_w-1:0] clk_cnt_t;          // cycle counter within one bit.

	localparam clk_cnt_t bit_last = clk_cnt_t'(clks_per_bit - 1);     // last cycle of a bit.
	localparam clk_cnt_t bit_half = clk_cnt_t'(clks_per_bit / 2 - 1); // middle of a bit.

	// ~~~~~~~~ framing ~~~~~~~~~~~~~~~~~~~~~~~
	localparam int max_len = 16;                      // payload bytes per frame.

	typedef logic [7:0]   byte_t;                     // one serial character.
	typedef logic [127:0] frame_buf_t;                // byte i at bits 8i+7:8i.
	typedef logic [4:0]   frame_len_t;                // payload length 0 to 16.

	localparam byte_t frame_char = 8'h26;             // the "&" delimiter.

endpackage
